// ==== src/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

    // ########################################################################
    // bus geometry
    // ########################################################################

    parameter int WORD_W     = 32;
    parameter int ADDR_W_BUS = 32;

    // each scalar register keeps the low half of the written word
    parameter int SCALAR_W   = 16;

    // ########################################################################
    // register map, every register address has bit 31 set
    // ########################################################################

    parameter logic [ADDR_W_BUS-1:0] CONV_START      = 32'h8000_0000;
    parameter logic [ADDR_W_BUS-1:0] CONV_RESET      = 32'h8000_0004;
    parameter logic [ADDR_W_BUS-1:0] CONV_STATUS     = 32'h8000_0008;
    parameter logic [ADDR_W_BUS-1:0] CONV_FM_DIM     = 32'h8000_000C;
    parameter logic [ADDR_W_BUS-1:0] CONV_INPUT_FM   = 32'h8000_0010;
    parameter logic [ADDR_W_BUS-1:0] CONV_OUTPUT_FM  = 32'h8000_0014;
    parameter logic [ADDR_W_BUS-1:0] CONV_WEIGHT_OFF = 32'h8000_0018;

    // ########################################################################
    // status word bit positions
    // ########################################################################

    parameter int STAT_DONE   = 0;
    parameter int STAT_IDLE   = 1;
    parameter int STAT_ACTIVE = 2;

endpackage

`default_nettype wire

// ==== src/conv_store_steer.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_store_steer (
    input  wire logic [3:0]                  conv_we_i,
    input  wire logic [conv_pkg::WORD_W-1:0] data_i,
    output logic      [conv_pkg::WORD_W-1:0] data_o
);

    // halfword stores use the low 16 bits, byte stores the low 8 bits
    always_comb begin
        case (conv_we_i)
            4'b1111: data_o = data_i;
            4'b0011: data_o = {16'h0000, data_i[15:0]};
            4'b1100: data_o = {data_i[15:0], 16'h0000};
            4'b0001: data_o = {24'h00_0000, data_i[7:0]};
            4'b0010: data_o = {16'h0000, data_i[7:0], 8'h00};
            4'b0100: data_o = {8'h00, data_i[7:0], 16'h0000};
            4'b1000: data_o = {data_i[7:0], 24'h00_0000};
            default: data_o = data_i;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/conv_mmio_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_mmio_ctrl #(
    parameter int MEM_AW = 10
) (
    input  wire logic                                clk,
    input  wire logic                                arst_n_i,
    input  wire logic [3:0]                          conv_we_i,
    input  wire logic [conv_pkg::ADDR_W_BUS-1:0]     cont_addr_i,
    input  wire logic [conv_pkg::WORD_W-1:0]         cont_data_i,
    output logic      [conv_pkg::WORD_W-1:0]         cont_data_o,
    output logic                                     conv_active_o,
    input  wire logic                                conv_idle_i,
    input  wire logic                                conv_done_i,
    output logic                                     conv_start_o,
    output logic                                     conv_rst_o,
    output logic      [conv_pkg::SCALAR_W-1:0]       conv_fm_dim_o,
    output logic      [conv_pkg::SCALAR_W-1:0]       conv_ifm_offset_o,
    output logic      [conv_pkg::SCALAR_W-1:0]       conv_ofm_offset_o,
    output logic      [conv_pkg::SCALAR_W-1:0]       conv_wt_offset_o,
    output logic      [3:0]                          mem_a_we_o,
    output logic      [MEM_AW-1:0]                   mem_a_addr_o,
    output logic      [conv_pkg::WORD_W-1:0]         mem_a_wdata_o,
    input  wire logic [conv_pkg::WORD_W-1:0]         mem_a_rdata_i
);

    localparam int W  = conv_pkg::WORD_W;
    localparam int SW = conv_pkg::SCALAR_W;

    logic [W-1:0] store_data;
    logic [W-1:0] status_word;
    logic [W-1:0] reg_rdata;
    logic [W-1:0] rdata_q;
    logic         wr_any;
    logic         rd_any;
    logic         mem_sel;
    logic         hit_start, hit_reset, hit_status;
    logic         hit_dim, hit_ifm, hit_ofm, hit_wt, hit_reg;
    logic         start_ok;
    logic         active_q;
    logic         done_sticky_q;
    logic         idle_q;
    logic         rd_mem_q;

    conv_store_steer u_steer (
        .conv_we_i (conv_we_i),
        .data_i    (cont_data_i),
        .data_o    (store_data)
    );

    // ########################################################################
    // address decode
    // ########################################################################

    assign wr_any     = |conv_we_i;
    assign mem_sel    = ~cont_addr_i[conv_pkg::ADDR_W_BUS-1];
    assign hit_start  = (cont_addr_i == conv_pkg::CONV_START);
    assign hit_reset  = (cont_addr_i == conv_pkg::CONV_RESET);
    assign hit_status = (cont_addr_i == conv_pkg::CONV_STATUS);
    assign hit_dim    = (cont_addr_i == conv_pkg::CONV_FM_DIM);
    assign hit_ifm    = (cont_addr_i == conv_pkg::CONV_INPUT_FM);
    assign hit_ofm    = (cont_addr_i == conv_pkg::CONV_OUTPUT_FM);
    assign hit_wt     = (cont_addr_i == conv_pkg::CONV_WEIGHT_OFF);
    assign hit_reg    = hit_start | hit_reset | hit_status | hit_dim | hit_ifm
                      | hit_ofm | hit_wt;
    assign rd_any     = ~wr_any & (mem_sel | hit_reg);

    assign conv_start_o = wr_any & hit_start;
    assign conv_rst_o   = wr_any & hit_reset;

    // a start only counts when the engine can take it
    assign start_ok = conv_start_o & conv_idle_i & ~active_q;

    assign mem_a_we_o    = mem_sel ? conv_we_i : 4'b0000;
    assign mem_a_addr_o  = cont_addr_i[MEM_AW+1:2];
    assign mem_a_wdata_o = store_data;

    // ########################################################################
    // scalar registers
    // ########################################################################

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            conv_fm_dim_o     <= '0;
            conv_ifm_offset_o <= '0;
            conv_ofm_offset_o <= '0;
            conv_wt_offset_o  <= '0;
        end else if (wr_any) begin
            if (hit_dim) conv_fm_dim_o <= store_data[SW-1:0];
            if (hit_ifm) conv_ifm_offset_o <= store_data[SW-1:0];
            if (hit_ofm) conv_ofm_offset_o <= store_data[SW-1:0];
            if (hit_wt) conv_wt_offset_o <= store_data[SW-1:0];
        end
    end

    // ########################################################################
    // run state and status
    // ########################################################################

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q      <= 1'b0;
            done_sticky_q <= 1'b0;
            idle_q        <= 1'b1;
        end else begin
            idle_q <= conv_idle_i;
            if (conv_rst_o) begin
                active_q <= 1'b0;
            end else if (start_ok) begin
                active_q <= 1'b1;
            end else if (conv_done_i) begin
                active_q <= 1'b0;
            end
            if (conv_rst_o || start_ok) begin
                done_sticky_q <= 1'b0;
            end else if (conv_done_i) begin
                done_sticky_q <= 1'b1;
            end
        end
    end

    assign conv_active_o = active_q;

    always_comb begin
        status_word                         = '0;
        status_word[conv_pkg::STAT_DONE]    = done_sticky_q;
        status_word[conv_pkg::STAT_IDLE]    = idle_q;
        status_word[conv_pkg::STAT_ACTIVE]  = active_q;
    end

    always_comb begin
        if (hit_status) begin
            reg_rdata = status_word;
        end else if (hit_dim) begin
            reg_rdata = {{(W-SW){1'b0}}, conv_fm_dim_o};
        end else if (hit_ifm) begin
            reg_rdata = {{(W-SW){1'b0}}, conv_ifm_offset_o};
        end else if (hit_ofm) begin
            reg_rdata = {{(W-SW){1'b0}}, conv_ofm_offset_o};
        end else if (hit_wt) begin
            reg_rdata = {{(W-SW){1'b0}}, conv_wt_offset_o};
        end else begin
            reg_rdata = '0;
        end
    end

    // ########################################################################
    // read port
    // ########################################################################

    // memory data is captured after its first cycle so it holds until the next read
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_mem_q <= 1'b0;
            rdata_q  <= '0;
        end else begin
            rd_mem_q <= rd_any & mem_sel;
            if (rd_any && !mem_sel) begin
                rdata_q <= reg_rdata;
            end else if (rd_mem_q) begin
                rdata_q <= mem_a_rdata_i;
            end
        end
    end

    assign cont_data_o = rd_mem_q ? mem_a_rdata_i : rdata_q;

endmodule

`default_nettype wire

// ==== src/conv_fm_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_fm_ram #(
    parameter int MEM_AW = 10
) (
    input  wire logic                        clk,
    input  wire logic [3:0]                  a_we_i,
    input  wire logic [MEM_AW-1:0]           a_addr_i,
    input  wire logic [conv_pkg::WORD_W-1:0] a_wdata_i,
    output logic      [conv_pkg::WORD_W-1:0] a_rdata_o,
    input  wire logic                        b_we_i,
    input  wire logic [MEM_AW-1:0]           b_addr_i,
    input  wire logic [conv_pkg::WORD_W-1:0] b_wdata_i,
    output logic      [conv_pkg::WORD_W-1:0] b_rdata_o
);

    localparam int DEPTH = 2 ** MEM_AW;

    logic [conv_pkg::WORD_W-1:0] mem [DEPTH];

    // port b is written last, so it wins a same-word collision
    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            if (a_we_i[k]) begin
                mem[a_addr_i][8*k +: 8] <= a_wdata_i[8*k +: 8];
            end
        end
        if (b_we_i) begin
            mem[b_addr_i] <= b_wdata_i;
        end
        a_rdata_o <= mem[a_addr_i];
        b_rdata_o <= mem[b_addr_i];
    end

endmodule

`default_nettype wire

// ==== src/conv2d_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv2d_engine #(
    parameter int MEM_AW = 10
) (
    input  wire logic                          clk,
    input  wire logic                          arst_n_i,
    input  wire logic                          start_i,
    input  wire logic                          abort_i,
    input  wire logic [conv_pkg::SCALAR_W-1:0] fm_dim_i,
    input  wire logic [conv_pkg::SCALAR_W-1:0] ifm_off_i,
    input  wire logic [conv_pkg::SCALAR_W-1:0] ofm_off_i,
    input  wire logic [conv_pkg::SCALAR_W-1:0] wt_off_i,
    output logic                               idle_o,
    output logic                               done_o,
    output logic      [MEM_AW-1:0]             mem_addr_o,
    output logic                               mem_we_o,
    output logic      [conv_pkg::WORD_W-1:0]   mem_wdata_o,
    input  wire logic [conv_pkg::WORD_W-1:0]   mem_rdata_i
);

    localparam int W  = conv_pkg::WORD_W;
    localparam int SW = conv_pkg::SCALAR_W;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_FM,
        S_RD_WT,
        S_MAC,
        S_WRITE,
        S_DONE
    } state_t;

    state_t        state_q;
    logic [SW-1:0] row_q, col_q;
    logic [1:0]    ki_q, kj_q;
    logic [W-1:0]  acc_q;
    logic [W-1:0]  fm_q;
    logic [W-1:0]  n_w, row_w, col_w, ki_w, kj_w;
    logic [W-1:0]  ifm_w, ofm_w, wt_w;
    logic [W-1:0]  fm_addr, wt_addr, of_addr, addr_sel;
    logic          last_tap, last_col, last_row;

    // ########################################################################
    // address arithmetic, all in word width so sums wrap the same way
    // ########################################################################

    assign n_w   = {{(W-SW){1'b0}}, fm_dim_i};
    assign row_w = {{(W-SW){1'b0}}, row_q};
    assign col_w = {{(W-SW){1'b0}}, col_q};
    assign ki_w  = {{(W-2){1'b0}}, ki_q};
    assign kj_w  = {{(W-2){1'b0}}, kj_q};
    assign ifm_w = {{(W-SW){1'b0}}, ifm_off_i};
    assign ofm_w = {{(W-SW){1'b0}}, ofm_off_i};
    assign wt_w  = {{(W-SW){1'b0}}, wt_off_i};

    assign fm_addr = ifm_w + (row_w + ki_w) * n_w + col_w + kj_w;
    assign wt_addr = wt_w + ki_w + ki_w + ki_w + kj_w;
    assign of_addr = ofm_w + row_w * (n_w - 2) + col_w;

    assign last_tap = (ki_q == 2'd2) && (kj_q == 2'd2);
    assign last_col = (col_w == n_w - 3);
    assign last_row = (row_w == n_w - 3);

    // ########################################################################
    // control FSM
    // ########################################################################

    // each tap takes three cycles: input read, weight read, accumulate
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
            row_q   <= '0;
            col_q   <= '0;
            ki_q    <= '0;
            kj_q    <= '0;
        end else if (abort_i) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        row_q   <= '0;
                        col_q   <= '0;
                        ki_q    <= '0;
                        kj_q    <= '0;
                        state_q <= (fm_dim_i < 3) ? S_DONE : S_RD_FM;
                    end
                end
                S_RD_FM: state_q <= S_RD_WT;
                S_RD_WT: state_q <= S_MAC;
                S_MAC: begin
                    if (last_tap) begin
                        ki_q    <= '0;
                        kj_q    <= '0;
                        state_q <= S_WRITE;
                    end else begin
                        if (kj_q == 2'd2) begin
                            kj_q <= '0;
                            ki_q <= ki_q + 2'd1;
                        end else begin
                            kj_q <= kj_q + 2'd1;
                        end
                        state_q <= S_RD_FM;
                    end
                end
                S_WRITE: begin
                    if (last_col) begin
                        col_q <= '0;
                        if (last_row) begin
                            state_q <= S_DONE;
                        end else begin
                            row_q   <= row_q + 1'b1;
                            state_q <= S_RD_FM;
                        end
                    end else begin
                        col_q   <= col_q + 1'b1;
                        state_q <= S_RD_FM;
                    end
                end
                S_DONE: state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // input word arrives in S_RD_WT, weight word in S_MAC
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE || state_q == S_WRITE) begin
            acc_q <= '0;
        end else if (state_q == S_MAC) begin
            acc_q <= acc_q + fm_q * mem_rdata_i;
        end
        if (state_q == S_RD_WT) begin
            fm_q <= mem_rdata_i;
        end
    end

    always_comb begin
        case (state_q)
            S_RD_WT: addr_sel = wt_addr;
            S_WRITE: addr_sel = of_addr;
            default: addr_sel = fm_addr;
        endcase
    end

    assign mem_addr_o  = addr_sel[MEM_AW-1:0];
    assign mem_we_o    = (state_q == S_WRITE);
    assign mem_wdata_o = acc_q;
    assign idle_o      = (state_q == S_IDLE);
    assign done_o      = (state_q == S_DONE);

endmodule

`default_nettype wire

// ==== src/conv_accel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_accel_top #(
    parameter int MEM_AW = 10
) (
    input  wire logic                            clk,
    input  wire logic                            arst_n_i,
    input  wire logic [3:0]                      conv_we_i,
    input  wire logic [conv_pkg::ADDR_W_BUS-1:0] cont_addr_i,
    input  wire logic [conv_pkg::WORD_W-1:0]     cont_data_i,
    output logic      [conv_pkg::WORD_W-1:0]     cont_data_o,
    output logic                                 conv_active_o
);

    logic                          conv_idle, conv_done;
    logic                          conv_start, conv_rst;
    logic [conv_pkg::SCALAR_W-1:0] fm_dim, ifm_off, ofm_off, wt_off;
    logic [3:0]                    mem_a_we;
    logic [MEM_AW-1:0]             mem_a_addr;
    logic [conv_pkg::WORD_W-1:0]   mem_a_wdata, mem_a_rdata;
    logic                          mem_b_we;
    logic [MEM_AW-1:0]             mem_b_addr;
    logic [conv_pkg::WORD_W-1:0]   mem_b_wdata, mem_b_rdata;

    conv_mmio_ctrl #(.MEM_AW(MEM_AW)) u_ctrl (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .conv_we_i         (conv_we_i),
        .cont_addr_i       (cont_addr_i),
        .cont_data_i       (cont_data_i),
        .cont_data_o       (cont_data_o),
        .conv_active_o     (conv_active_o),
        .conv_idle_i       (conv_idle),
        .conv_done_i       (conv_done),
        .conv_start_o      (conv_start),
        .conv_rst_o        (conv_rst),
        .conv_fm_dim_o     (fm_dim),
        .conv_ifm_offset_o (ifm_off),
        .conv_ofm_offset_o (ofm_off),
        .conv_wt_offset_o  (wt_off),
        .mem_a_we_o        (mem_a_we),
        .mem_a_addr_o      (mem_a_addr),
        .mem_a_wdata_o     (mem_a_wdata),
        .mem_a_rdata_i     (mem_a_rdata)
    );

    // cpu on port a, engine on port b
    conv_fm_ram #(.MEM_AW(MEM_AW)) u_ram (
        .clk       (clk),
        .a_we_i    (mem_a_we),
        .a_addr_i  (mem_a_addr),
        .a_wdata_i (mem_a_wdata),
        .a_rdata_o (mem_a_rdata),
        .b_we_i    (mem_b_we),
        .b_addr_i  (mem_b_addr),
        .b_wdata_i (mem_b_wdata),
        .b_rdata_o (mem_b_rdata)
    );

    conv2d_engine #(.MEM_AW(MEM_AW)) u_engine (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .start_i     (conv_start),
        .abort_i     (conv_rst),
        .fm_dim_i    (fm_dim),
        .ifm_off_i   (ifm_off),
        .ofm_off_i   (ofm_off),
        .wt_off_i    (wt_off),
        .idle_o      (conv_idle),
        .done_o      (conv_done),
        .mem_addr_o  (mem_b_addr),
        .mem_we_o    (mem_b_we),
        .mem_wdata_o (mem_b_wdata),
        .mem_rdata_i (mem_b_rdata)
    );

endmodule

`default_nettype wire

// ==== tb/conv_accel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_accel_tb;

    localparam int MEM_AW = 10;
    localparam int DEPTH  = 2 ** MEM_AW;
    // a 5x5 run takes about 260 cycles and the loads and readbacks of all
    // tests add about 1000 more, so this limit leaves a wide margin
    localparam int MAX_CYCLES = 20000;
    // bit 31 set but no register, so a parked bus neither reads nor writes
    localparam logic [31:0] IDLE_ADDR = 32'hFFFF_FFF0;

    logic        clk = 1'b0;
    logic        arst_n_i;
    logic [3:0]  conv_we_i;
    logic [31:0] cont_addr_i;
    logic [31:0] cont_data_i;
    logic [31:0] cont_data_o;
    logic        conv_active_o;

    logic [31:0] mem_model [DEPTH];
    int          cycle_count;
    int          errors;
    int          tests_ok;
    int          tests_bad;

    conv_accel_top #(.MEM_AW(MEM_AW)) UUT (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .conv_we_i     (conv_we_i),
        .cont_addr_i   (cont_addr_i),
        .cont_data_i   (cont_data_i),
        .cont_data_o   (cont_data_o),
        .conv_active_o (conv_active_o)
    );

    always #10 clk = ~clk;

    // ########################################################################
    // reference rules and bus access
    // ########################################################################

    // halfword stores take data bits 15:0, byte stores bits 7:0
    function automatic logic [31:0] lane_merge(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0]  mask);
        logic [31:0] lanes;
        logic [31:0] result;
        if (mask == 4'b1111) begin
            lanes = data;
        end else if (mask == 4'b0011 || mask == 4'b1100) begin
            lanes = {data[15:0], data[15:0]};
        end else begin
            lanes = {4{data[7:0]}};
        end
        for (int k = 0; k < 4; k++) begin
            result[8*k +: 8] = mask[k] ? lanes[8*k +: 8] : old[8*k +: 8];
        end
        return result;
    endfunction

    function automatic logic [31:0] stat(input bit done, input bit idle, input bit active);
        logic [31:0] s;
        s = '0;
        s[conv_pkg::STAT_DONE]   = done;
        s[conv_pkg::STAT_IDLE]   = idle;
        s[conv_pkg::STAT_ACTIVE] = active;
        return s;
    endfunction

    function automatic logic [31:0] fill_word(input int w);
        return (w * 32'h0101_0101) ^ 32'hC3C3_0000;
    endfunction

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] mask);
        int idx;
        idx = addr[MEM_AW+1:2];
        cont_addr_i = addr;
        cont_data_i = data;
        conv_we_i   = mask;
        @(negedge clk);
        conv_we_i   = 4'b0000;
        cont_addr_i = IDLE_ADDR;
        if (!addr[31]) begin
            mem_model[idx] = lane_merge(mem_model[idx], data, mask);
        end
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        cont_addr_i = addr;
        conv_we_i   = 4'b0000;
        @(negedge clk);
        data = cont_data_o;
        cont_addr_i = IDLE_ADDR;
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mem(input int w);
        logic [31:0] got;
        bus_read(w * 4, got);
        check_word($sformatf("mem[%0d]", w), got, mem_model[w]);
    endtask

    task automatic check_status(input logic [31:0] exp);
        logic [31:0] got;
        bus_read(conv_pkg::CONV_STATUS, got);
        check_word("status", got, exp);
    endtask

    // ########################################################################
    // convolution runs
    // ########################################################################

    task automatic load_run(input int n, input int ifm, input int ofm, input int wt,
                            input bit big);
        logic [31:0] v;
        for (int k = 0; k < n * n + 9; k++) begin
            v = big ? $urandom : $urandom % 64;
            bus_write(k < n * n ? (ifm + k) * 4 : (wt + k - n * n) * 4, v, 4'hF);
        end
        bus_write(conv_pkg::CONV_FM_DIM, n, 4'hF);
        bus_write(conv_pkg::CONV_INPUT_FM, ifm, 4'hF);
        bus_write(conv_pkg::CONV_OUTPUT_FM, ofm, 4'hF);
        bus_write(conv_pkg::CONV_WEIGHT_OFF, wt, 4'hF);
    endtask

    task automatic model_conv(input int n, input int ifm, input int ofm, input int wt);
        logic [31:0] acc;
        for (int r = 0; r < n - 2; r++) begin
            for (int c = 0; c < n - 2; c++) begin
                acc = '0;
                for (int t = 0; t < 9; t++) begin
                    acc += mem_model[(ifm + (r + t / 3) * n + c + t % 3) % DEPTH]
                         * mem_model[(wt + t) % DEPTH];
                end
                mem_model[(ofm + r * (n - 2) + c) % DEPTH] = acc;
            end
        end
    endtask

    task automatic start_run();
        bus_write(conv_pkg::CONV_START, 32'h1, 4'hF);
        assert (conv_active_o === 1'b1) else begin
            $display("conv_active_o did not rise after the start write");
            errors++;
        end
    endtask

    // status idle lags the engine by a cycle, hence the two spare cycles
    task automatic wait_done(input int limit);
        int waited;
        waited = 0;
        while (conv_active_o === 1'b1 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        assert (waited < limit) else begin
            $display("engine still active after %0d cycles", limit);
            errors++;
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic check_outputs(input int n, input int ofm);
        for (int k = 0; k < (n - 2) * (n - 2); k++) begin
            check_mem(ofm + k);
        end
    endtask

    // ########################################################################
    // directed tests
    // ########################################################################

    task automatic reset_state();
        check_word("cont_data_o", cont_data_o, 32'h0);
        check_word("conv_active_o", {31'b0, conv_active_o}, 32'h0);
        check_status(stat(0, 1, 0));
    endtask

    task automatic mem_lanes();
        logic [3:0] masks [7];
        masks = '{4'b0011, 4'b1100, 4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b1111};
        for (int w = 16; w < 24; w++) begin
            bus_write(w * 4, $urandom, 4'hF);
        end
        for (int k = 0; k < 7; k++) begin
            bus_write((16 + k) * 4, $urandom, masks[k]);
        end
        for (int w = 16; w < 24; w++) begin
            check_mem(w);
        end
        // read data holds while the bus is parked
        @(negedge clk);
        check_word("cont_data_o", cont_data_o, mem_model[23]);
    endtask

    task automatic conv_5x5();
        load_run(5, 64, 128, 100, 0);
        model_conv(5, 64, 128, 100);
        start_run();
        wait_done(600);
        check_status(stat(1, 1, 0));
        check_outputs(5, 128);
    endtask

    task automatic start_while_busy();
        load_run(5, 64, 128, 100, 0);
        model_conv(5, 64, 128, 100);
        start_run();
        repeat (20) @(negedge clk);
        bus_write(conv_pkg::CONV_START, 32'h1, 4'hF);
        check_word("conv_active_o", {31'b0, conv_active_o}, 32'h1);
        wait_done(600);
        check_outputs(5, 128);
        // large values so the sums wrap
        load_run(4, 160, 200, 180, 1);
        model_conv(4, 160, 200, 180);
        start_run();
        wait_done(400);
        check_status(stat(1, 1, 0));
        check_outputs(4, 200);
        bus_write(conv_pkg::CONV_STATUS, 32'hFFFF_FFFF, 4'hF);
        repeat (2) @(negedge clk);
        check_status(stat(1, 1, 0));
    endtask

    task automatic abort_run();
        load_run(5, 64, 128, 100, 0);
        start_run();
        repeat (40) @(negedge clk);
        bus_write(conv_pkg::CONV_RESET, 32'h1, 4'hF);
        check_word("conv_active_o", {31'b0, conv_active_o}, 32'h0);
        repeat (2) @(negedge clk);
        check_status(stat(0, 1, 0));
        for (int w = 128; w < 137; w++) begin
            bus_write(w * 4, fill_word(w), 4'hF);
        end
        model_conv(5, 64, 128, 100);
        start_run();
        wait_done(600);
        check_status(stat(1, 1, 0));
        check_outputs(5, 128);
    endtask

    task automatic small_dim();
        for (int w = 240; w < 244; w++) begin
            bus_write(w * 4, fill_word(w), 4'hF);
        end
        bus_write(conv_pkg::CONV_FM_DIM, 32'd2, 4'hF);
        bus_write(conv_pkg::CONV_OUTPUT_FM, 32'd240, 4'hF);
        start_run();
        wait_done(20);
        check_status(stat(1, 1, 0));
        for (int w = 240; w < 244; w++) begin
            check_mem(w);
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: no end of run after %0d cycles", MAX_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int mark;
        void'($urandom(11));
        arst_n_i    = 1'b0;
        conv_we_i   = 4'b0000;
        cont_addr_i = IDLE_ADDR;
        cont_data_i = '0;
        errors      = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        mark = errors;
        reset_state();
        report("reset_state", mark);
        mark = errors;
        mem_lanes();
        report("mem_lanes", mark);
        mark = errors;
        conv_5x5();
        report("conv_5x5", mark);
        mark = errors;
        start_while_busy();
        report("start_while_busy", mark);
        mark = errors;
        abort_run();
        report("abort_run", mark);
        mark = errors;
        small_dim();
        report("small_dim", mark);
        $display("tests ok: %0d, tests with errors: %0d", tests_ok, tests_bad);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/conv_pkg.sv
src/conv_store_steer.sv
src/conv_mmio_ctrl.sv
src/conv_fm_ram.sv
src/conv2d_engine.sv
src/conv_accel_top.sv
tb/conv_accel_tb.sv

// ==== Bender.yml ====
package:
  name: conv_accel

sources:
  - files:
      - src/conv_pkg.sv
      - src/conv_store_steer.sv
      - src/conv_mmio_ctrl.sv
      - src/conv_fm_ram.sv
      - src/conv2d_engine.sv
      - src/conv_accel_top.sv
  - target: test
    files:
      - tb/conv_accel_tb.sv
